//--- verilog/priv_pkg.sv
`default_nettype none

package priv_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  dcause_t;

    // hart execution state
    typedef enum logic {
        RUN_MODE,
        DEBUG_MODE
    } priv_state_t;

    // machine mode csr addresses
    localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
    localparam csr_addr_t MTVEC_ADDR     = 12'h305;
    localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
    localparam csr_addr_t MEPC_ADDR      = 12'h341;
    localparam csr_addr_t MCAUSE_ADDR    = 12'h342;

    // debug mode csr addresses
    localparam csr_addr_t DCSR_ADDR      = 12'h7b0;
    localparam csr_addr_t DPC_ADDR       = 12'h7b1;
    localparam csr_addr_t DSCRATCH0_ADDR = 12'h7b2;
    localparam csr_addr_t DSCRATCH1_ADDR = 12'h7b3;

    // dcsr writable bits: ebreakm, ebreaks, ebreaku, step, prv
    localparam word_t DCSR_WMASK = 32'h0000_b017;

    // xdebugver = 4, prv = machine
    localparam word_t DCSR_RESET = 32'h4000_0003;

    // dcsr field positions
    localparam int DCSR_EBREAKM_BIT = 15;
    localparam int DCSR_CAUSE_MSB   = 8;
    localparam int DCSR_CAUSE_LSB   = 6;
    localparam int DCSR_NMIP_BIT    = 3;

    // dcsr cause codes
    localparam dcause_t DCAUSE_EBREAK  = 3'd1;
    localparam dcause_t DCAUSE_HALTREQ = 3'd3;

    // mcause exception code for ebreak
    localparam word_t MCAUSE_BREAKPOINT = 32'd3;

    // mepc and mtvec hold word aligned targets
    localparam word_t ADDR_ALIGN_MASK = 32'hffff_fffc;

    // debug rom entry point
    localparam pc_t DEBUG_ROM_ADDR = 32'h0000_0800;

endpackage

`default_nettype wire

//--- verilog/csr_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module csr_bus_arbiter (
    input  logic                CLK,
    input  logic                nRST,
    // pipeline requester
    input  logic                pipe_csr_req,
    input  logic                pipe_csr_we,
    input  priv_pkg::csr_addr_t pipe_csr_addr,
    input  priv_pkg::word_t     pipe_csr_wdata,
    output priv_pkg::word_t     pipe_csr_rdata,
    output logic                pipe_csr_illegal,
    output logic                pipe_csr_stall,
    // debugger requester
    input  logic                dbg_csr_req,
    input  logic                dbg_csr_we,
    input  priv_pkg::csr_addr_t dbg_csr_addr,
    input  priv_pkg::word_t     dbg_csr_wdata,
    output priv_pkg::word_t     dbg_csr_rdata,
    output logic                dbg_csr_illegal,
    // replies from the csr files
    input  logic                m_hit,
    input  priv_pkg::word_t     m_rdata,
    input  logic                d_hit,
    input  priv_pkg::word_t     d_rdata,
    // shared bus
    output logic                bus_req,
    output logic                bus_we,
    output priv_pkg::csr_addr_t bus_addr,
    output priv_pkg::word_t     bus_wdata
);
    // no registers in this module
    logic            grant_dbg;
    logic            grant_pipe;
    logic            any_hit;
    priv_pkg::word_t reply_data;

    // debugger always wins
    assign grant_dbg  = dbg_csr_req;
    assign grant_pipe = pipe_csr_req & ~dbg_csr_req;

    assign bus_req   = grant_dbg | grant_pipe;
    assign bus_we    = grant_dbg ? dbg_csr_we : (grant_pipe & pipe_csr_we);
    assign bus_addr  = grant_dbg ? dbg_csr_addr : pipe_csr_addr;
    assign bus_wdata = grant_dbg ? dbg_csr_wdata : pipe_csr_wdata;

    // the two files decode disjoint addresses
    assign any_hit = m_hit | d_hit;

    always_comb begin : reply_select
        if (m_hit) begin
            reply_data = m_rdata;
        end else if (d_hit) begin
            reply_data = d_rdata;
        end else begin
            reply_data = '0;
        end
    end

    // steer reply to the granted side only
    assign dbg_csr_rdata    = grant_dbg ? reply_data : '0;
    assign pipe_csr_rdata   = grant_pipe ? reply_data : '0;
    assign dbg_csr_illegal  = grant_dbg & ~any_hit;
    assign pipe_csr_illegal = grant_pipe & ~any_hit;

    // pipeline holds its request while the debugger owns the bus
    assign pipe_csr_stall = pipe_csr_req & grant_dbg;

endmodule

`default_nettype wire

//--- verilog/priv_machine_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module priv_machine_csrs (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                bus_req,
    input  logic                bus_we,
    input  priv_pkg::csr_addr_t bus_addr,
    input  priv_pkg::word_t     bus_wdata,
    input  logic                inject_mtrap,
    input  priv_pkg::pc_t       next_mepc,
    input  priv_pkg::word_t     next_mcause,
    output logic                m_hit,
    output priv_pkg::word_t     m_rdata,
    output priv_pkg::word_t     mtvec
);
    priv_pkg::word_t mstatus_q, mstatus_n;
    priv_pkg::word_t mtvec_q, mtvec_n;
    priv_pkg::word_t mscratch_q, mscratch_n;
    priv_pkg::word_t mepc_q, mepc_n;
    priv_pkg::word_t mcause_q, mcause_n;
    logic            wr_en;

    // address decode and read mux
    always_comb begin : read_logic
        m_hit   = bus_req;
        m_rdata = '0;
        case (bus_addr)
            priv_pkg::MSTATUS_ADDR:  m_rdata = mstatus_q;
            priv_pkg::MTVEC_ADDR:    m_rdata = mtvec_q;
            priv_pkg::MSCRATCH_ADDR: m_rdata = mscratch_q;
            priv_pkg::MEPC_ADDR:     m_rdata = mepc_q;
            priv_pkg::MCAUSE_ADDR:   m_rdata = mcause_q;
            default:                 m_hit   = 1'b0;
        endcase
    end

    assign wr_en = m_hit & bus_we;

    always_comb begin : next_logic
        mstatus_n  = mstatus_q;
        mtvec_n    = mtvec_q;
        mscratch_n = mscratch_q;
        mepc_n     = mepc_q;
        mcause_n   = mcause_q;

        if (wr_en) begin
            case (bus_addr)
                priv_pkg::MSTATUS_ADDR:  mstatus_n  = bus_wdata;
                priv_pkg::MTVEC_ADDR:    mtvec_n    = bus_wdata & priv_pkg::ADDR_ALIGN_MASK;
                priv_pkg::MSCRATCH_ADDR: mscratch_n = bus_wdata;
                priv_pkg::MEPC_ADDR:     mepc_n     = bus_wdata & priv_pkg::ADDR_ALIGN_MASK;
                priv_pkg::MCAUSE_ADDR:   mcause_n   = bus_wdata;
                default: ;
            endcase
        end

        // trap entry beats a csr write in the same cycle
        if (inject_mtrap) begin
            mepc_n   = next_mepc;
            mcause_n = next_mcause;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else begin
            mstatus_q  <= mstatus_n;
            mtvec_q    <= mtvec_n;
            mscratch_q <= mscratch_n;
            mepc_q     <= mepc_n;
            mcause_q   <= mcause_n;
        end
    end

    assign mtvec = mtvec_q;

endmodule

`default_nettype wire

//--- verilog/priv_debug_csrs.sv
`timescale 1ns/1ps
`default_nettype none

module priv_debug_csrs (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                bus_req,
    input  logic                bus_we,
    input  priv_pkg::csr_addr_t bus_addr,
    input  priv_pkg::word_t     bus_wdata,
    input  logic                inject_debug,
    input  priv_pkg::pc_t       next_dpc,
    input  priv_pkg::dcause_t   next_cause,
    output logic                d_hit,
    output priv_pkg::word_t     d_rdata,
    output priv_pkg::pc_t       dpc,
    output logic                ebreakm
);
    priv_pkg::word_t dcsr_q, dcsr_n;
    priv_pkg::word_t dpc_q, dpc_n;
    priv_pkg::word_t dscratch0_q, dscratch0_n;
    priv_pkg::word_t dscratch1_q, dscratch1_n;
    priv_pkg::word_t dcsr_view;
    logic            wr_en;

    // nmip has no source here
    always_comb begin : dcsr_read_view
        dcsr_view = dcsr_q;
        dcsr_view[priv_pkg::DCSR_NMIP_BIT] = 1'b0;
    end

    always_comb begin : read_logic
        d_hit   = bus_req;
        d_rdata = '0;
        case (bus_addr)
            priv_pkg::DCSR_ADDR:      d_rdata = dcsr_view;
            priv_pkg::DPC_ADDR:       d_rdata = dpc_q;
            priv_pkg::DSCRATCH0_ADDR: d_rdata = dscratch0_q;
            priv_pkg::DSCRATCH1_ADDR: d_rdata = dscratch1_q;
            default:                  d_hit   = 1'b0;
        endcase
    end

    assign wr_en = d_hit & bus_we;

    always_comb begin : next_logic
        dcsr_n      = dcsr_q;
        dpc_n       = dpc_q;
        dscratch0_n = dscratch0_q;
        dscratch1_n = dscratch1_q;

        if (wr_en) begin
            case (bus_addr)
                // WARL write where only masked bits follow the data
                priv_pkg::DCSR_ADDR: begin
                    dcsr_n = (dcsr_q & ~priv_pkg::DCSR_WMASK)
                           | (bus_wdata & priv_pkg::DCSR_WMASK);
                end
                priv_pkg::DPC_ADDR:       dpc_n       = bus_wdata;
                priv_pkg::DSCRATCH0_ADDR: dscratch0_n = bus_wdata;
                priv_pkg::DSCRATCH1_ADDR: dscratch1_n = bus_wdata;
                default: ;
            endcase
        end

        // debug entry records pc and reason
        if (inject_debug) begin
            dpc_n = next_dpc;
            dcsr_n[priv_pkg::DCSR_CAUSE_MSB:priv_pkg::DCSR_CAUSE_LSB] = next_cause;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dcsr_q      <= priv_pkg::DCSR_RESET;
            dpc_q       <= '0;
            dscratch0_q <= '0;
            dscratch1_q <= '0;
        end else begin
            dcsr_q      <= dcsr_n;
            dpc_q       <= dpc_n;
            dscratch0_q <= dscratch0_n;
            dscratch1_q <= dscratch1_n;
        end
    end

    assign dpc     = dpc_q;
    assign ebreakm = dcsr_q[priv_pkg::DCSR_EBREAKM_BIT];

endmodule

`default_nettype wire

//--- verilog/priv_trap_handler.sv
`timescale 1ns/1ps
`default_nettype none

module priv_trap_handler (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  haltreq,
    input  logic                  ebreak,
    input  priv_pkg::pc_t         trap_pc,
    input  logic                  dret,
    input  logic                  ebreakm,
    input  priv_pkg::word_t       mtvec,
    input  priv_pkg::pc_t         dpc,
    output logic                  inject_debug,
    output priv_pkg::pc_t         next_dpc,
    output priv_pkg::dcause_t     next_cause,
    output logic                  inject_mtrap,
    output priv_pkg::pc_t         next_mepc,
    output priv_pkg::word_t       next_mcause,
    output logic                  redirect,
    output priv_pkg::pc_t         redirect_pc,
    output logic                  debug_mode
);
    priv_pkg::priv_state_t state, next_state;
    logic                  in_run;
    logic                  halt_entry;
    logic                  ebreak_entry;
    logic                  ebreak_in_debug;
    logic                  dret_return;
    logic                  take_event;
    priv_pkg::pc_t         target_pc;

    assign in_run = (state == priv_pkg::RUN_MODE);

    // haltreq first, then ebreak, then dret
    assign halt_entry      = in_run & haltreq;
    assign ebreak_entry    = in_run & ~haltreq & ebreak;
    assign ebreak_in_debug = ~in_run & ebreak;
    assign dret_return     = ~in_run & ~ebreak & dret;

    // dcsr.ebreakm picks debug entry or machine trap
    assign inject_debug = halt_entry | (ebreak_entry & ebreakm);
    assign inject_mtrap = ebreak_entry & ~ebreakm;

    assign next_dpc    = trap_pc;
    assign next_cause  = halt_entry ? priv_pkg::DCAUSE_HALTREQ : priv_pkg::DCAUSE_EBREAK;
    assign next_mepc   = trap_pc;
    assign next_mcause = priv_pkg::MCAUSE_BREAKPOINT;

    assign take_event = inject_debug | inject_mtrap | ebreak_in_debug | dret_return;

    always_comb begin : next_state_logic
        next_state = state;
        target_pc  = priv_pkg::DEBUG_ROM_ADDR;
        if (inject_debug) begin
            next_state = priv_pkg::DEBUG_MODE;
        end else if (inject_mtrap) begin
            target_pc = mtvec;
        end else if (dret_return) begin
            next_state = priv_pkg::RUN_MODE;
            target_pc  = dpc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= priv_pkg::RUN_MODE;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else begin
            state    <= next_state;
            redirect <= take_event;
            if (take_event) begin
                redirect_pc <= target_pc;
            end
        end
    end

    assign debug_mode = (state == priv_pkg::DEBUG_MODE);

endmodule

`default_nettype wire

//--- verilog/priv_block.sv
`timescale 1ns/1ps
`default_nettype none

module priv_block (
    input  logic                CLK,
    input  logic                nRST,
    // pipeline csr port
    input  logic                pipe_csr_req,
    input  logic                pipe_csr_we,
    input  priv_pkg::csr_addr_t pipe_csr_addr,
    input  priv_pkg::word_t     pipe_csr_wdata,
    output priv_pkg::word_t     pipe_csr_rdata,
    output logic                pipe_csr_illegal,
    output logic                pipe_csr_stall,
    // debugger abstract register port
    input  logic                dbg_csr_req,
    input  logic                dbg_csr_we,
    input  priv_pkg::csr_addr_t dbg_csr_addr,
    input  priv_pkg::word_t     dbg_csr_wdata,
    output priv_pkg::word_t     dbg_csr_rdata,
    output logic                dbg_csr_illegal,
    // trap events and pc redirect
    input  logic                haltreq,
    input  logic                ebreak,
    input  priv_pkg::pc_t       trap_pc,
    input  logic                dret,
    output logic                redirect,
    output priv_pkg::pc_t       redirect_pc,
    output logic                debug_mode
);
    // shared csr bus
    logic                bus_req;
    logic                bus_we;
    priv_pkg::csr_addr_t bus_addr;
    priv_pkg::word_t     bus_wdata;

    // replies from the two csr files
    logic                m_hit;
    priv_pkg::word_t     m_rdata;
    logic                d_hit;
    priv_pkg::word_t     d_rdata;

    // trap handler to csr files
    logic                inject_debug;
    priv_pkg::pc_t       next_dpc;
    priv_pkg::dcause_t   next_cause;
    logic                inject_mtrap;
    priv_pkg::pc_t       next_mepc;
    priv_pkg::word_t     next_mcause;

    // csr values the handler needs
    priv_pkg::word_t     mtvec;
    priv_pkg::pc_t       dpc;
    logic                ebreakm;

    // all port names match the nets above
    csr_bus_arbiter u_arbiter (.*);

    priv_machine_csrs u_machine_csrs (.*);

    priv_debug_csrs u_debug_csrs (.*);

    priv_trap_handler u_trap_handler (.*);

endmodule

`default_nettype wire

//--- sim/priv_block_tb.sv
`timescale 1ns/1ps
`default_nettype none

module priv_block_tb;

    localparam int    CLK_PERIOD     = 20;
    localparam int    SETTLE         = 5;
    localparam int    RESET_CYCLES   = 16;
    localparam int    CYCLES_PER_TEST = 20;
    localparam int    REDIRECT_WAIT  = 4;
    localparam string TEST_FILE      = "sim/priv_tests.txt";

    logic                CLK;
    logic                nRST;
    logic                pipe_csr_req;
    logic                pipe_csr_we;
    priv_pkg::csr_addr_t pipe_csr_addr;
    priv_pkg::word_t     pipe_csr_wdata;
    priv_pkg::word_t     pipe_csr_rdata;
    logic                pipe_csr_illegal;
    logic                pipe_csr_stall;
    logic                dbg_csr_req;
    logic                dbg_csr_we;
    priv_pkg::csr_addr_t dbg_csr_addr;
    priv_pkg::word_t     dbg_csr_wdata;
    priv_pkg::word_t     dbg_csr_rdata;
    logic                dbg_csr_illegal;
    logic                haltreq;
    logic                ebreak;
    priv_pkg::pc_t       trap_pc;
    logic                dret;
    logic                redirect;
    priv_pkg::pc_t       redirect_pc;
    logic                debug_mode;

    // test table with one entry per data line
    string               name_q[$];
    string               op_q[$];
    priv_pkg::csr_addr_t addr_q[$];
    priv_pkg::word_t     data_q[$];
    priv_pkg::word_t     exp_q[$];
    priv_pkg::pc_t       pc_q[$];

    integer seed = 32'h3401_0ac3;
    int     errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    priv_block dut0 (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // watchdog limit is set once the test table is known
    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input priv_pkg::word_t expected,
                              input priv_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input priv_pkg::pc_t expected,
                            input priv_pkg::pc_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic idle_inputs();
        pipe_csr_req   = 1'b0;
        pipe_csr_we    = 1'b0;
        pipe_csr_addr  = '0;
        pipe_csr_wdata = '0;
        dbg_csr_req    = 1'b0;
        dbg_csr_we     = 1'b0;
        dbg_csr_addr   = '0;
        dbg_csr_wdata  = '0;
        haltreq        = 1'b0;
        ebreak         = 1'b0;
        dret           = 1'b0;
        trap_pc        = '0;
    endtask

    // lines starting with # are skipped
    task automatic load_tests(output logic ok);
        int                  fd;
        int                  n;
        string               tok;
        string               op;
        string               rest;
        priv_pkg::csr_addr_t addr;
        priv_pkg::word_t     data;
        priv_pkg::word_t     exp;
        priv_pkg::pc_t       pc;
        fd = $fopen(TEST_FILE, "r");
        ok = 1'b0;
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);
                end else if (n == 1) begin
                    n = $fscanf(fd, " %s %h %h %h %h", op, addr, data, exp, pc);
                    name_q.push_back(tok);
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    exp_q.push_back(exp);
                    pc_q.push_back(pc);
                end
            end
            $fclose(fd);
            ok = (name_q.size() > 0);
        end
    endtask

    task automatic csr_write(input string name, input logic from_dbg,
                             input priv_pkg::csr_addr_t addr, input priv_pkg::word_t data,
                             input logic exp_illegal);
        @(negedge CLK);
        if (from_dbg) begin
            dbg_csr_req   = 1'b1;
            dbg_csr_we    = 1'b1;
            dbg_csr_addr  = addr;
            dbg_csr_wdata = data;
        end else begin
            pipe_csr_req   = 1'b1;
            pipe_csr_we    = 1'b1;
            pipe_csr_addr  = addr;
            pipe_csr_wdata = data;
        end
        #(SETTLE);
        check_flag({name, " illegal"}, exp_illegal,
                   from_dbg ? dbg_csr_illegal : pipe_csr_illegal);
        @(negedge CLK);
        idle_inputs();
    endtask

    task automatic csr_read(input string name, input logic from_dbg,
                            input priv_pkg::csr_addr_t addr, input priv_pkg::word_t expected);
        @(negedge CLK);
        if (from_dbg) begin
            dbg_csr_req   = 1'b1;
            dbg_csr_addr  = addr;
            dbg_csr_wdata = $random(seed);
        end else begin
            pipe_csr_req   = 1'b1;
            pipe_csr_addr  = addr;
            pipe_csr_wdata = $random(seed);
        end
        #(SETTLE);
        check_word({name, " rdata"}, expected, from_dbg ? dbg_csr_rdata : pipe_csr_rdata);
        @(negedge CLK);
        idle_inputs();
    endtask

    // both sides write the same csr and the pipeline holds until granted
    task automatic both_write(input string name, input priv_pkg::csr_addr_t addr,
                              input priv_pkg::word_t dbg_value,
                              input priv_pkg::word_t pipe_value);
        @(negedge CLK);
        dbg_csr_req    = 1'b1;
        dbg_csr_we     = 1'b1;
        dbg_csr_addr   = addr;
        dbg_csr_wdata  = dbg_value;
        pipe_csr_req   = 1'b1;
        pipe_csr_we    = 1'b1;
        pipe_csr_addr  = addr;
        pipe_csr_wdata = pipe_value;
        #(SETTLE);
        check_flag({name, " stall while debugger writes"}, 1'b1, pipe_csr_stall);
        @(negedge CLK);
        dbg_csr_req = 1'b0;
        dbg_csr_we  = 1'b0;
        #(SETTLE);
        check_flag({name, " stall after release"}, 1'b0, pipe_csr_stall);
        // old value seen by the pipeline is the one the debugger wrote
        check_word({name, " debugger value"}, dbg_value, pipe_csr_rdata);
        @(negedge CLK);
        idle_inputs();
    endtask

    // flags hold redirect in the high digit and debug_mode in the low digit
    task automatic trap_event(input string name, input string op, input priv_pkg::pc_t pc,
                              input priv_pkg::word_t flags, input priv_pkg::pc_t exp_pc);
        int   waited;
        logic want_redirect;
        logic want_debug;
        want_redirect = flags[4];
        want_debug    = flags[0];
        waited        = 0;
        @(negedge CLK);
        trap_pc = pc;
        haltreq = (op == "HALT");
        ebreak  = (op == "EBRK");
        dret    = (op == "DRET");
        @(negedge CLK);
        idle_inputs();
        while (!redirect && waited < REDIRECT_WAIT) begin
            @(negedge CLK);
            waited++;
        end
        if (want_redirect && !redirect) begin
            $display("%s: no redirect seen within %0d cycles after the event",
                     name, REDIRECT_WAIT);
            errors++;
        end else if (want_redirect) begin
            check_flag({name, " redirect in next cycle"}, 1'b1, waited == 0);
            check_pc({name, " redirect_pc"}, exp_pc, redirect_pc);
        end else begin
            check_flag({name, " redirect"}, 1'b0, redirect);
        end
        check_flag({name, " debug_mode"}, want_debug, debug_mode);
        if (redirect) begin
            @(negedge CLK);
            check_flag({name, " redirect pulse width"}, 1'b0, redirect);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            pass_count++;
            $display("PASSED %s", name);
        end else begin
            fail_count++;
        end
    endtask

    task automatic run_test(input int i);
        case (op_q[i])
            "PWR":  csr_write(name_q[i], 1'b0, addr_q[i], data_q[i], exp_q[i][0]);
            "DWR":  csr_write(name_q[i], 1'b1, addr_q[i], data_q[i], exp_q[i][0]);
            "PRD":  csr_read(name_q[i], 1'b0, addr_q[i], exp_q[i]);
            "DRD":  csr_read(name_q[i], 1'b1, addr_q[i], exp_q[i]);
            "BOTH": both_write(name_q[i], addr_q[i], data_q[i], exp_q[i]);
            "HALT", "EBRK", "DRET": begin
                trap_event(name_q[i], op_q[i], data_q[i], exp_q[i], pc_q[i]);
            end
            default: begin
                $display("%s: unknown operation %s in the test file", name_q[i], op_q[i]);
                errors++;
            end
        endcase
    endtask

    initial begin : main
        logic load_ok;
        int   start_errors;
        CLK  = 1'b0;
        nRST = 1'b0;
        idle_inputs();
        load_tests(load_ok);
        if (!load_ok) begin
            $display("could not read any test lines from %s", TEST_FILE);
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycle_limit = CYCLES_PER_TEST * name_q.size() + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge CLK);
            @(negedge CLK);
            nRST = 1'b1;
            // outputs right after reset with idle inputs
            start_errors = errors;
            @(negedge CLK);
            check_flag("reset redirect", 1'b0, redirect);
            check_flag("reset pipe_csr_stall", 1'b0, pipe_csr_stall);
            check_flag("reset pipe_csr_illegal", 1'b0, pipe_csr_illegal);
            check_flag("reset dbg_csr_illegal", 1'b0, dbg_csr_illegal);
            check_flag("reset debug_mode", 1'b0, debug_mode);
            finish_test("reset_outputs", start_errors);
            foreach (name_q[i]) begin
                start_errors = errors;
                run_test(i);
                finish_test(name_q[i], start_errors);
            end
            $display("tests: %0d passed, %0d failed", pass_count, fail_count);
            if (errors == 0 && fail_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/priv_tests.txt
# name op addr data expected pc, all hex; reads compare data, writes expect the illegal flag
# trap lines: data is trap_pc, expected is redirect and debug_mode as two digits, pc is target
rst_dcsr        DRD  7b0 00000000 40000003 00000000
rst_dpc         DRD  7b1 00000000 00000000 00000000
rst_dscratch0   DRD  7b2 00000000 00000000 00000000
rst_dscratch1   DRD  7b3 00000000 00000000 00000000
rst_mstatus     PRD  300 00000000 00000000 00000000
rst_mtvec       PRD  305 00000000 00000000 00000000
rst_mscratch    PRD  340 00000000 00000000 00000000
rst_mepc        PRD  341 00000000 00000000 00000000
rst_mcause      PRD  342 00000000 00000000 00000000
dcsr_all_ones   DWR  7b0 ffffffff 00000000 00000000
dcsr_warl_read  DRD  7b0 00000000 4000b017 00000000
dcsr_restore    DWR  7b0 00000003 00000000 00000000
mscratch_write  PWR  340 a5a55a5a 00000000 00000000
mscratch_read   PRD  340 00000000 a5a55a5a 00000000
mtvec_write     PWR  305 00001237 00000000 00000000
mtvec_read      PRD  305 00000000 00001234 00000000
dscratch1_write PWR  7b3 cafef00d 00000000 00000000
dscratch1_read  PRD  7b3 00000000 cafef00d 00000000
unmapped_pipe   PWR  344 12345678 00000001 00000000
unmapped_dbg    DWR  7b4 87654321 00000001 00000000
mscratch_kept   PRD  340 00000000 a5a55a5a 00000000
dscratch1_kept  DRD  7b3 00000000 cafef00d 00000000
arb_both        BOTH 340 11112222 33334444 00000000
arb_read        PRD  340 00000000 33334444 00000000
halt_entry      HALT 000 00001000 00000011 00000800
halt_dpc        DRD  7b1 00000000 00001000 00000000
halt_cause      DRD  7b0 00000000 400000c3 00000000
halt_ignored    HALT 000 00002000 00000001 00000000
halt_dpc_kept   DRD  7b1 00000000 00001000 00000000
dret_return     DRET 000 00000000 00000010 00001000
dret_in_run     DRET 000 00000000 00000000 00000000
ebreak_mtrap    EBRK 000 00003000 00000010 00001234
mtrap_mepc      PRD  341 00000000 00003000 00000000
mtrap_mcause    PRD  342 00000000 00000003 00000000
ebreakm_set     DWR  7b0 00008003 00000000 00000000
ebreak_debug    EBRK 000 00004000 00000011 00000800
ebreak_cause    DRD  7b0 00000000 40008043 00000000
ebreak_dpc      DRD  7b1 00000000 00004000 00000000

//--- filelist.f
verilog/priv_pkg.sv
verilog/csr_bus_arbiter.sv
verilog/priv_machine_csrs.sv
verilog/priv_debug_csrs.sv
verilog/priv_trap_handler.sv
verilog/priv_block.sv
sim/priv_block_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the privilege block testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module priv_block_tb -f filelist.f -o priv_block_sim \
    && ./obj_dir/priv_block_sim > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Simulation PASSED$" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
